// ==== src.f ====
+incdir+logic
logic/rv_pkg.sv
logic/control_unit.sv
logic/imm_extend.sv
logic/alu.sv
logic/register_file.sv
logic/datapath.sv
logic/instr_memory.sv
logic/data_memory.sv
logic/rv_core.sv
tests/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, decide on the log contents
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -f src.f --top-module rv_core_tb \
    && ./obj_dir/Vrv_core_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^STATUS: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module rv_core_tb;

    // six tests of at most 8 reset, 64 load and 64 run cycles each plus margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                clk;
    logic                rst_n;
    logic                prog_we;
    rv_pkg::pc_t         prog_addr;
    rv_pkg::word_t       prog_data;
    rv_pkg::pc_t         pc;
    logic                store_valid;
    rv_pkg::word_t       store_addr;
    rv_pkg::word_t       store_data;
    logic                trap;

    // program image and store bookkeeping
    rv_pkg::word_t prog [$];
    rv_pkg::word_t exp_addr [$];
    rv_pkg::word_t exp_data [$];
    int            next_off;
    int            end_pc;
    int            cycle_count = 0;
    string         test_name;

    // trap observations from the last run
    int            trap_hits;
    rv_pkg::pc_t   trap_pc;
    rv_pkg::pc_t   trap_next_pc;
    logic          trap_store;

    rv_core DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .pc          (pc),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .trap        (trap)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // --------------------
    // failure reporting
    // --------------------
    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(rv_pkg::word_t got, rv_pkg::word_t exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s in %s, got %h, expected %h",
                     $time, what, test_name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(rv_pkg::pc_t got, rv_pkg::pc_t exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s in %s, got %0d, expected %0d",
                     $time, what, test_name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s in %s, got %b, expected %b",
                     $time, what, test_name, got, exp);
            abort_run();
        end
    endtask

    // run limit over the whole simulation
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // --------------------
    // instruction encoders
    // --------------------
    function automatic rv_pkg::word_t r_type(rv_pkg::opcode_e op, int f7, int rs2, int rs1,
                                             int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic rv_pkg::word_t i_type(rv_pkg::opcode_e op, int imm, int rs1, int f3,
                                             int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    // store offset split around the rd slot
    function automatic rv_pkg::word_t s_type(rv_pkg::opcode_e op, int imm, int rs2, int rs1,
                                             int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], op};
    endfunction

    function automatic rv_pkg::word_t b_type(rv_pkg::opcode_e op, int imm, int rs2, int rs1,
                                             int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], op};
    endfunction

    function automatic rv_pkg::word_t j_type(rv_pkg::opcode_e op, int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op};
    endfunction

    function automatic rv_pkg::word_t u_type(rv_pkg::opcode_e op, int imm20, int rd);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    // --------------------
    // program building
    // --------------------
    task automatic start_program(string name);
        test_name = name;
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        next_off = 0;
    endtask

    task automatic emit(rv_pkg::word_t w);
        prog.push_back(w);
    endtask

    function automatic int cur_addr();
        return prog.size() * 4;
    endfunction

    // lui plus addi with the upper part rounded for the sign of the low 12 bits
    task automatic load_const(int rd, rv_pkg::word_t v);
        logic [19:0] up;
        up = v[31:12] + {19'd0, v[11]};
        emit(u_type(rv_pkg::OP_LUI, int'(up), rd));
        emit(i_type(rv_pkg::OP_I, int'(v[11:0]), rd, 0, rd));
    endtask

    // sw rs2 to the next free slot off x0
    task automatic emit_store(int rs2, rv_pkg::word_t exp, bit expected);
        emit(s_type(rv_pkg::OP_STORE, next_off, rs2, 0, 2));
        if (expected) begin
            exp_addr.push_back(rv_pkg::word_t'(next_off));
            exp_data.push_back(exp);
        end
        next_off += 4;
    endtask

    // final jal to itself marks the end
    task automatic close_program();
        end_pc = cur_addr();
        emit(j_type(rv_pkg::OP_JAL, 0, 0));
    endtask

    // --------------------
    // load, run, compare
    // --------------------
    task automatic load_and_release();
        @(posedge clk);
        rst_n   <= 1'b0;
        prog_we <= 1'b0;
        repeat (8) @(posedge clk);
        for (int i = 0; i < prog.size(); i++) begin
            prog_we   <= 1'b1;
            prog_addr <= rv_pkg::pc_t'(i * 4);
            prog_data <= prog[i];
            @(posedge clk);
        end
        prog_we <= 1'b0;
        rst_n   <= 1'b1;
    endtask

    task automatic run_program(int traps_expected);
        bit after_trap;
        bit first_cycle;
        int n_stores;
        after_trap  = 1'b0;
        first_cycle = 1'b1;
        n_stores    = 0;
        trap_hits   = 0;
        load_and_release();
        // outputs sampled mid cycle
        while (1) begin
            @(negedge clk);
            if (first_cycle) begin
                check_pc(pc, rv_pkg::pc_t'(0), "pc after reset release");
                first_cycle = 1'b0;
            end
            if (after_trap) begin
                trap_next_pc = pc;
                after_trap   = 1'b0;
            end
            if (int'(pc) == end_pc) begin
                break;
            end
            // each store is compared as it happens
            if (store_valid) begin
                if (n_stores >= exp_addr.size()) begin
                    $display("%s: core made an unexpected store to address %h",
                             test_name, store_addr);
                    abort_run();
                end else begin
                    check_word(store_addr, exp_addr[n_stores], "store address");
                    check_word(store_data, exp_data[n_stores], "store data");
                    n_stores++;
                end
            end
            if (trap) begin
                trap_hits++;
                trap_pc    = pc;
                trap_store = store_valid;
                after_trap = 1'b1;
            end
        end
        if (trap_hits != traps_expected) begin
            $display("%s: saw %0d traps where %0d were expected",
                     test_name, trap_hits, traps_expected);
            abort_run();
        end
        if (n_stores != exp_addr.size()) begin
            $display("%s: core made %0d stores where %0d were expected",
                     test_name, n_stores, exp_addr.size());
            abort_run();
        end
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_arith();
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t imm_w;
        logic [11:0]   imm;
        start_program("arith");
        for (int n = 0; n < 2; n++) begin
            a     = $urandom;
            b     = $urandom;
            imm   = 12'($urandom);
            imm_w = {{20{imm[11]}}, imm};
            load_const(1, a);
            load_const(2, b);
            emit(r_type(rv_pkg::OP_R, 'h00, 2, 1, 0, 3));
            emit_store(3, a + b, 1);
            emit(r_type(rv_pkg::OP_R, 'h20, 2, 1, 0, 4));
            emit_store(4, a - b, 1);
            emit(r_type(rv_pkg::OP_R, 'h00, 2, 1, 7, 5));
            emit_store(5, a & b, 1);
            emit(r_type(rv_pkg::OP_R, 'h00, 2, 1, 6, 6));
            emit_store(6, a | b, 1);
            emit(r_type(rv_pkg::OP_R, 'h00, 2, 1, 2, 7));
            emit_store(7, {31'd0, $signed(a) < $signed(b)}, 1);
            emit(r_type(rv_pkg::OP_R, 'h00, 1, 2, 2, 7));
            emit_store(7, {31'd0, $signed(b) < $signed(a)}, 1);
            // immediate forms against a
            emit(i_type(rv_pkg::OP_I, int'(imm), 1, 0, 8));
            emit_store(8, a + imm_w, 1);
            emit(i_type(rv_pkg::OP_I, int'(imm), 1, 7, 9));
            emit_store(9, a & imm_w, 1);
            emit(i_type(rv_pkg::OP_I, int'(imm), 1, 6, 10));
            emit_store(10, a | imm_w, 1);
            emit(i_type(rv_pkg::OP_I, int'(imm), 1, 2, 11));
            emit_store(11, {31'd0, $signed(a) < $signed(imm_w)}, 1);
        end
        close_program();
        run_program(0);
    endtask

    task automatic test_memory();
        rv_pkg::word_t v;
        logic [19:0]   up;
        v  = $urandom;
        up = 20'($urandom);
        start_program("memory");
        load_const(5, v);
        emit_store(5, v, 1);
        // read back the slot just written and store it again
        emit(i_type(rv_pkg::OP_LOAD, next_off - 4, 0, 2, 6));
        emit_store(6, v, 1);
        emit(u_type(rv_pkg::OP_LUI, int'(up), 7));
        emit_store(7, {up, 12'd0}, 1);
        close_program();
        run_program(0);
    endtask

    task automatic test_branch();
        rv_pkg::word_t v;
        v = $urandom;
        start_program("branch");
        load_const(1, v);
        emit(i_type(rv_pkg::OP_I, 0, 1, 0, 2));
        emit(i_type(rv_pkg::OP_I, 1, 1, 0, 3));
        emit(i_type(rv_pkg::OP_I, 'h111, 0, 0, 10));
        emit(i_type(rv_pkg::OP_I, 'h222, 0, 0, 11));
        // equal registers skip the 111 marker
        emit(b_type(rv_pkg::OP_BRANCH, 8, 2, 1, 0));
        emit_store(10, 'h111, 0);
        emit_store(11, 'h222, 1);
        // unequal registers fall through
        emit(b_type(rv_pkg::OP_BRANCH, 8, 3, 1, 0));
        emit_store(10, 'h111, 1);
        emit_store(11, 'h222, 1);
        close_program();
        run_program(0);
    endtask

    task automatic test_jump();
        int a;
        int b;
        start_program("jump");
        emit(i_type(rv_pkg::OP_I, 'h5a, 0, 0, 9));
        a = cur_addr();
        emit(j_type(rv_pkg::OP_JAL, 12, 5));
        emit_store(9, 'h5a, 0);
        emit_store(9, 'h5a, 0);
        emit_store(5, rv_pkg::word_t'(a + 4), 1);
        b = cur_addr();
        emit(j_type(rv_pkg::OP_JAL, 8, 6));
        emit_store(9, 'h5a, 0);
        emit_store(6, rv_pkg::word_t'(b + 4), 1);
        close_program();
        run_program(0);
    endtask

    task automatic test_illegal();
        start_program("illegal");
        emit(i_type(rv_pkg::OP_I, 'h55, 0, 0, 1));
        // opcode 7f is outside the supported set
        emit(32'h0000_007f);
        emit_store(1, 'h55, 0);
        // park any stray fetch until the vector
        while (cur_addr() < `RV_TRAP_VECTOR) begin
            emit(j_type(rv_pkg::OP_JAL, 0, 0));
        end
        emit(i_type(rv_pkg::OP_I, 'h3c, 0, 0, 2));
        emit_store(2, 'h3c, 1);
        close_program();
        run_program(1);
        check_pc(trap_pc, rv_pkg::pc_t'(4), "pc of trapping instruction");
        check_flag(trap_store, 1'b0, "store strobe during trap");
        check_pc(trap_next_pc, rv_pkg::pc_t'(`RV_TRAP_VECTOR), "pc after trap");
    endtask

    task automatic test_x0();
        start_program("x0");
        load_const(1, $urandom | 32'h1);
        emit(i_type(rv_pkg::OP_I, 'h123, 0, 0, 0));
        emit(u_type(rv_pkg::OP_LUI, 'habcde, 0));
        emit(r_type(rv_pkg::OP_R, 'h00, 1, 1, 0, 0));
        emit(i_type(rv_pkg::OP_LOAD, 0, 0, 2, 0));
        emit_store(0, 32'h0, 1);
        // x0 as a source reads zero
        emit(i_type(rv_pkg::OP_I, 7, 0, 0, 5));
        emit_store(5, 32'h7, 1);
        close_program();
        run_program(0);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        clk       = 1'b0;
        rst_n     <= 1'b0;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        void'($urandom(54305));
        test_arith();
        test_memory();
        test_branch();
        test_jump();
        test_illegal();
        test_x0();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           prog_we,
    input  rv_pkg::pc_t    prog_addr,
    input  rv_pkg::word_t  prog_data,
    output rv_pkg::pc_t    pc,
    output logic           store_valid,
    output rv_pkg::word_t  store_addr,
    output rv_pkg::word_t  store_data,
    output logic           trap
);

    rv_pkg::word_t       instr;
    rv_pkg::word_t       read_data;
    rv_pkg::word_t       alu_result;
    rv_pkg::word_t       write_data;
    rv_pkg::opcode_e     op;
    logic [2:0]          funct3;
    logic                funct7_5;
    logic                alu_zero;
    logic                reg_write;
    logic                alu_src;
    logic                mem_write;
    rv_pkg::alu_op_e     alu_op;
    rv_pkg::imm_src_e    imm_src;
    rv_pkg::result_src_e result_src;
    rv_pkg::pc_src_e     pc_src;

    // --------------------
    // control
    // --------------------
    control_unit u_control_unit (
        .rst_n      (rst_n),
        .op         (op),
        .funct3     (funct3),
        .funct7_5   (funct7_5),
        .alu_zero   (alu_zero),
        .reg_write  (reg_write),
        .alu_src    (alu_src),
        .mem_write  (mem_write),
        .trap       (trap),
        .alu_op     (alu_op),
        .imm_src    (imm_src),
        .result_src (result_src),
        .pc_src     (pc_src)
    );

    datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .reg_write  (reg_write),
        .alu_src    (alu_src),
        .alu_op     (alu_op),
        .imm_src    (imm_src),
        .result_src (result_src),
        .pc_src     (pc_src),
        .pc         (pc),
        .op         (op),
        .funct3     (funct3),
        .funct7_5   (funct7_5),
        .alu_zero   (alu_zero),
        .alu_result (alu_result),
        .write_data (write_data)
    );

    // --------------------
    // memories
    // --------------------
    instr_memory u_instr_memory (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (pc),
        .rdata (instr)
    );

    data_memory u_data_memory (
        .clk   (clk),
        .we    (mem_write),
        .addr  (alu_result),
        .wdata (write_data),
        .rdata (read_data)
    );

    // store port mirrors the data memory write side
    assign store_valid = mem_write;
    assign store_addr  = alu_result;
    assign store_data  = write_data;

endmodule

// ==== logic/data_memory.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module data_memory (
    input  logic           clk,
    input  logic           we,
    input  rv_pkg::word_t  addr,
    input  rv_pkg::word_t  wdata,
    output rv_pkg::word_t  rdata
);

    localparam int IDX_W = $clog2(`RV_DMEM_DEPTH);

    rv_pkg::word_t mem [0:`RV_DMEM_DEPTH-1];
    logic [IDX_W-1:0] idx;

    // word index, upper address bits wrap
    assign idx = addr[2 +: IDX_W];

    // --------------------
    // access
    // --------------------
    // sw commits at the end of the cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    // lw sees data in the same cycle
    assign rdata = mem[idx];

endmodule

// ==== logic/instr_memory.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module instr_memory (
    input  logic           clk,
    input  logic           we,
    input  rv_pkg::pc_t    waddr,
    input  rv_pkg::word_t  wdata,
    input  rv_pkg::pc_t    raddr,
    output rv_pkg::word_t  rdata
);

    localparam int IDX_W = $clog2(`RV_IMEM_DEPTH);

    rv_pkg::word_t mem [0:`RV_IMEM_DEPTH-1];

    // program load, byte address like the pc
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[2 +: IDX_W]] <= wdata;
        end
    end

    // fetch, low two bits dropped
    assign rdata = mem[raddr[2 +: IDX_W]];

endmodule

// ==== logic/datapath.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_pkg::word_t        instr,
    input  rv_pkg::word_t        read_data,
    input  logic                 reg_write,
    input  logic                 alu_src,
    input  rv_pkg::alu_op_e      alu_op,
    input  rv_pkg::imm_src_e     imm_src,
    input  rv_pkg::result_src_e  result_src,
    input  rv_pkg::pc_src_e      pc_src,
    output rv_pkg::pc_t          pc,
    output rv_pkg::opcode_e      op,
    output logic [2:0]           funct3,
    output logic                 funct7_5,
    output logic                 alu_zero,
    output rv_pkg::word_t        alu_result,
    output rv_pkg::word_t        write_data
);

    rv_pkg::pc_t   pc_next;
    rv_pkg::pc_t   pc_plus4;
    rv_pkg::pc_t   pc_target;
    rv_pkg::word_t link_word;
    rv_pkg::word_t imm_ext;
    rv_pkg::word_t src_a;
    rv_pkg::word_t src_b;
    rv_pkg::word_t rs2_data;
    rv_pkg::word_t result;

    // --------------------
    // fetch
    // --------------------
    assign pc_plus4  = pc + rv_pkg::pc_t'(4);
    // branch and jal offsets wrap inside the pc width
    assign pc_target = pc + imm_ext[`RV_PC_WIDTH-1:0];

    always_comb begin
        case (pc_src)
            rv_pkg::PC_TARGET: pc_next = pc_target;
            rv_pkg::PC_TRAP:   pc_next = rv_pkg::pc_t'(`RV_TRAP_VECTOR);
            default:           pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // --------------------
    // decode fields
    // --------------------
    assign op       = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];

    register_file u_register_file (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (reg_write),
        .a1    (instr[19:15]),
        .a2    (instr[24:20]),
        .a3    (instr[11:7]),
        .wd3   (result),
        .rd1   (src_a),
        .rd2   (rs2_data)
    );

    imm_extend u_imm_extend (
        .instr   (instr),
        .imm_src (imm_src),
        .imm_ext (imm_ext)
    );

    // --------------------
    // execute
    // --------------------
    // immediate replaces rs2 for i-type, loads and stores
    assign src_b = alu_src ? imm_ext : rs2_data;

    alu u_alu (
        .src_a  (src_a),
        .src_b  (src_b),
        .alu_op (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // --------------------
    // writeback
    // --------------------
    // jal return address, zero extended to a word
    assign link_word = {{(`RV_XLEN-`RV_PC_WIDTH){1'b0}}, pc_plus4};

    always_comb begin
        case (result_src)
            rv_pkg::RES_MEM:  result = read_data;
            rv_pkg::RES_IMM:  result = imm_ext;
            rv_pkg::RES_LINK: result = link_word;
            default:          result = alu_result;
        endcase
    end

    // store data is rs2 itself
    assign write_data = rs2_data;

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/100ps

module register_file (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           we,
    input  logic [4:0]     a1,
    input  logic [4:0]     a2,
    input  logic [4:0]     a3,
    input  rv_pkg::word_t  wd3,
    output rv_pkg::word_t  rd1,
    output rv_pkg::word_t  rd2
);

    rv_pkg::word_t regs [0:31];

    // write port, x0 never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && a3 != 5'd0) begin
            regs[a3] <= wd3;
        end
    end

    // read ports, x0 forced to zero
    assign rd1 = (a1 == 5'd0) ? '0 : regs[a1];
    assign rd2 = (a2 == 5'd0) ? '0 : regs[a2];

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module alu (
    input  rv_pkg::word_t    src_a,
    input  rv_pkg::word_t    src_b,
    input  rv_pkg::alu_op_e  alu_op,
    output rv_pkg::word_t    result,
    output logic             zero
);

    // signed compare for slt
    logic lt;

    assign lt = $signed(src_a) < $signed(src_b);

    // --------------------
    // operation select
    // --------------------
    always_comb begin
        case (alu_op)
            rv_pkg::ALU_ADD: result = src_a + src_b;
            rv_pkg::ALU_SUB: result = src_a - src_b;
            rv_pkg::ALU_AND: result = src_a & src_b;
            rv_pkg::ALU_OR:  result = src_a | src_b;
            rv_pkg::ALU_SLT: result = {{(`RV_XLEN-1){1'b0}}, lt};
            default:         result = '0;
        endcase
    end

    // beq looks at this after a sub
    assign zero = (result == '0);

endmodule

// ==== logic/imm_extend.sv ====
`timescale 1ns/100ps

module imm_extend (
    input  rv_pkg::word_t     instr,
    input  rv_pkg::imm_src_e  imm_src,
    output rv_pkg::word_t     imm_ext
);

    // sign bit is always instr[31]
    always_comb begin
        case (imm_src)
            // addi, lw
            rv_pkg::IMM_I: imm_ext = {{20{instr[31]}}, instr[31:20]};
            // sw, split around rd field
            rv_pkg::IMM_S: imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // beq, halfword aligned offset
            rv_pkg::IMM_B: imm_ext = {{19{instr[31]}}, instr[31], instr[7],
                                      instr[30:25], instr[11:8], 1'b0};
            // jal, 21 bit offset
            rv_pkg::IMM_J: imm_ext = {{11{instr[31]}}, instr[31], instr[19:12],
                                      instr[20], instr[30:21], 1'b0};
            // lui, upper 20 bits
            rv_pkg::IMM_U: imm_ext = {instr[31:12], 12'b0};
            default:       imm_ext = '0;
        endcase
    end

endmodule

// ==== logic/control_unit.sv ====
`timescale 1ns/100ps

module control_unit (
    input  logic                 rst_n,
    input  rv_pkg::opcode_e      op,
    input  logic [2:0]           funct3,
    input  logic                 funct7_5,
    input  logic                 alu_zero,
    output logic                 reg_write,
    output logic                 alu_src,
    output logic                 mem_write,
    output logic                 trap,
    output rv_pkg::alu_op_e      alu_op,
    output rv_pkg::imm_src_e     imm_src,
    output rv_pkg::result_src_e  result_src,
    output rv_pkg::pc_src_e      pc_src
);

    // main decoder outputs
    logic dec_reg_write;
    logic dec_mem_write;
    logic use_funct;
    logic is_branch;
    logic is_jump;
    logic illegal;

    // --------------------
    // main decoder
    // --------------------
    always_comb begin
        dec_reg_write = 1'b0;
        dec_mem_write = 1'b0;
        alu_src       = 1'b0;
        imm_src       = rv_pkg::IMM_I;
        result_src    = rv_pkg::RES_ALU;
        use_funct     = 1'b0;
        is_branch     = 1'b0;
        is_jump       = 1'b0;
        illegal       = 1'b0;
        case (op)
            rv_pkg::OP_R: begin
                dec_reg_write = 1'b1;
                use_funct     = 1'b1;
            end
            rv_pkg::OP_I: begin
                dec_reg_write = 1'b1;
                alu_src       = 1'b1;
                use_funct     = 1'b1;
            end
            rv_pkg::OP_LOAD: begin
                dec_reg_write = 1'b1;
                alu_src       = 1'b1;
                result_src    = rv_pkg::RES_MEM;
            end
            rv_pkg::OP_STORE: begin
                dec_mem_write = 1'b1;
                alu_src       = 1'b1;
                imm_src       = rv_pkg::IMM_S;
            end
            // compare by subtraction, zero flag decides
            rv_pkg::OP_BRANCH: begin
                imm_src   = rv_pkg::IMM_B;
                is_branch = 1'b1;
            end
            rv_pkg::OP_JAL: begin
                dec_reg_write = 1'b1;
                imm_src       = rv_pkg::IMM_J;
                result_src    = rv_pkg::RES_LINK;
                is_jump       = 1'b1;
            end
            // immediate straight to rd
            rv_pkg::OP_LUI: begin
                dec_reg_write = 1'b1;
                imm_src       = rv_pkg::IMM_U;
                result_src    = rv_pkg::RES_IMM;
            end
            default: illegal = 1'b1;
        endcase
    end

    // --------------------
    // alu decoder
    // --------------------
    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        if (is_branch) begin
            alu_op = rv_pkg::ALU_SUB;
        end else if (use_funct) begin
            case (funct3)
                // sub only in r-type, addi has no funct7
                3'b000:  alu_op = (op == rv_pkg::OP_R && funct7_5) ? rv_pkg::ALU_SUB
                                                                   : rv_pkg::ALU_ADD;
                3'b010:  alu_op = rv_pkg::ALU_SLT;
                3'b110:  alu_op = rv_pkg::ALU_OR;
                3'b111:  alu_op = rv_pkg::ALU_AND;
                default: alu_op = rv_pkg::ALU_ADD;
            endcase
        end
    end

    // --------------------
    // next pc and strobes
    // --------------------
    always_comb begin
        if (illegal) begin
            pc_src = rv_pkg::PC_TRAP;
        end else if (is_jump || (is_branch && funct3 == 3'b000 && alu_zero)) begin
            pc_src = rv_pkg::PC_TARGET;
        end else begin
            pc_src = rv_pkg::PC_SEQ;
        end
        // nothing commits while in reset
        reg_write = rst_n & dec_reg_write;
        mem_write = rst_n & dec_mem_write;
        trap      = rst_n & illegal;
    end

endmodule

// ==== logic/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

    // basic words
    typedef logic [`RV_XLEN-1:0]     word_t;
    typedef logic [`RV_PC_WIDTH-1:0] pc_t;

    // --------------------
    // decode enums
    // --------------------
    // rv32i major opcodes, only the supported subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} imm_src_e;

    // writeback mux order
    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_IMM, RES_LINK} result_src_e;

    typedef enum logic [1:0] {PC_SEQ, PC_TARGET, PC_TRAP} pc_src_e;

endpackage

// ==== logic/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// --------------------
// widths
// --------------------
// data word, registers and alu
`define RV_XLEN 32
// program counter, byte address
`define RV_PC_WIDTH 16

// --------------------
// memories
// --------------------
`define RV_IMEM_DEPTH 256
`define RV_DMEM_DEPTH 256

// pc target on an illegal opcode
`define RV_TRAP_VECTOR 100

`endif
